// File: src/umi_pkg.sv
// UMI packet layout, request and response opcodes, address group constants
package umi_pkg;

   // ########################################################################
   // Widths
   // ########################################################################
   localparam int UMI_AW = 64;                          // Address width
   localparam int UMI_DW = 64;                          // Data carried per packet

   // Request opcodes
   localparam logic [4:0] UMI_REQ_READ    = 5'd1;
   localparam logic [4:0] UMI_REQ_WRITE   = 5'd3;       // Acknowledged write
   localparam logic [4:0] UMI_REQ_POSTED  = 5'd5;       // Write, no response
   localparam logic [4:0] UMI_REQ_RDMA    = 5'd7;       // Dropped by bridge
   localparam logic [4:0] UMI_REQ_ATOMIC  = 5'd9;       // Dropped by bridge

   // Response opcodes
   localparam logic [4:0] UMI_RESP_READ   = 5'd2;
   localparam logic [4:0] UMI_RESP_WRITE  = 5'd4;

   localparam logic [2:0] UMI_SIZE_WORD   = 3'd2;       // 2**2 = 4 bytes
   localparam logic [1:0] UMI_ERR_SLV     = 2'b10;      // Target slave error

   // Address group check on dstaddr
   localparam int                    UMI_GRP_OFFSET = 24;
   localparam int                    UMI_GRP_AW     = 8;
   localparam logic [UMI_GRP_AW-1:0] UMI_GRP_ID     = 8'h5A;

   // ########################################################################
   // Packet types
   // ########################################################################
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] size;                                 // log2 of bytes
      logic [7:0] len;                                  // Beats minus one
      logic [7:0] atype;
      logic [1:0] prot;
      logic [1:0] err;
      logic       eom;
      logic       eof;
      logic [1:0] hostid;
   } umi_cmd_t;

   typedef struct packed {
      umi_cmd_t          cmd;
      logic [UMI_AW-1:0] dstaddr;
      logic [UMI_AW-1:0] srcaddr;
      logic [UMI_DW-1:0] data;
   } umi_pkt_t;                                         // Requests and responses

endpackage

// File: src/apb_pkg.sv
// APB request and response bundles and register file address map
package apb_pkg;

   localparam int APB_AW    = 32;                       // Address width
   localparam int APB_RW    = 32;                       // Register width
   localparam int APB_NREGS = 16;                       // Register count
   localparam int APB_IDX_W = $clog2(APB_NREGS);        // Word index width

   // First unmapped byte address
   localparam logic [APB_AW-1:0] APB_MAP_BYTES = APB_NREGS * (APB_RW / 8);

   typedef struct packed {
      logic                  sel;
      logic                  enable;                    // High in access phase
      logic                  write;                     // 0 read, 1 write
      logic [APB_AW-1:0]     addr;                      // Byte address
      logic [APB_RW-1:0]     wdata;
      logic [APB_RW/8-1:0]   strb;                      // Byte lanes
      logic [2:0]            prot;
   } apb_req_t;

   typedef struct packed {
      logic                  ready;
      logic [APB_RW-1:0]     rdata;                     // Valid with ready
      logic                  slverr;                    // Valid with ready
   } apb_resp_t;

endpackage

// File: src/umi_cmd_decode.sv
// UMI request classifier with word size, alignment and address group checks
`timescale 1ns/1ps

module umi_cmd_decode import umi_pkg::*; (
   input  umi_cmd_t          cmd,
   input  logic [UMI_AW-1:0] dstaddr,
   output logic              is_read,
   output logic              is_write,
   output logic              is_posted,
   output logic              supported
);

   logic known;                                         // One of the handled opcodes
   logic word_access;
   logic aligned;
   logic group_match;

   // ########################################################################
   // Opcode classification
   // ########################################################################
   always_comb begin
      is_read   = 1'b0;
      is_write  = 1'b0;
      is_posted = 1'b0;
      case (cmd.opcode)
         UMI_REQ_READ:   is_read   = 1'b1;
         UMI_REQ_WRITE:  is_write  = 1'b1;
         UMI_REQ_POSTED: is_posted = 1'b1;
         UMI_REQ_RDMA,
         UMI_REQ_ATOMIC: ;                              // No APB mapping
         default: ;                                     // Link, responses, unknown
      endcase
   end

   // ########################################################################
   // Access checks
   // ########################################################################
   assign known       = is_read | is_write | is_posted;
   assign word_access = (cmd.size == UMI_SIZE_WORD);    // Single 32-bit word only
   assign aligned     = (dstaddr[1:0] == 2'b00);        // Natural word alignment
   assign group_match = (dstaddr[UMI_GRP_OFFSET +: UMI_GRP_AW] == UMI_GRP_ID);

   // Anything else is accepted and dropped by the bridge
   assign supported = known & word_access & aligned & group_match;

endmodule

// File: src/umi_apb_bridge.sv
// UMI to APB bridge, one APB transfer per request with a response packet on completion
`timescale 1ns/1ps

module umi_apb_bridge import umi_pkg::*, apb_pkg::*; (
   input  logic      clk,
   input  logic      nreset,
   // UMI request
   input  logic      req_valid,
   input  umi_pkt_t  req,
   output logic      req_ready,
   // UMI response
   output logic      resp_valid,
   output umi_pkt_t  resp,
   input  logic      resp_ready,
   // APB requester
   output apb_req_t  apb_req,
   input  apb_resp_t apb_resp
);

   // Captured request
   umi_cmd_t          cmd_r;
   logic [UMI_AW-1:0] dstaddr_r;
   logic [UMI_AW-1:0] srcaddr_r;
   logic [APB_RW-1:0] wdata_r;                          // Low data word only

   umi_pkt_t          resp_r;                           // Response held until taken
   umi_cmd_t          resp_cmd;
   logic              enable_r;                         // APB access phase
   logic              resp_valid_r;

   logic              accept;                           // UMI handshake this cycle
   logic              start;                            // Accepted and supported
   logic              done;                             // APB transfer completes
   umi_cmd_t          cur_cmd;
   logic [UMI_AW-1:0] cur_dstaddr;

   logic              is_read;
   logic              is_write;
   logic              is_posted;
   logic              supported;

   // ########################################################################
   // Request side
   // ########################################################################
   assign req_ready = ~enable_r & ~resp_valid_r;        // One transaction in flight
   assign accept    = req_valid & req_ready;
   assign start     = accept & supported;
   assign done      = enable_r & apb_resp.ready;

   // Live request in the setup cycle, captured one afterwards
   assign cur_cmd     = accept ? req.cmd : cmd_r;
   assign cur_dstaddr = accept ? req.dstaddr : dstaddr_r;

   umi_cmd_decode decode_i (
      .cmd       (cur_cmd),
      .dstaddr   (cur_dstaddr),
      .is_read   (is_read),
      .is_write  (is_write),
      .is_posted (is_posted),
      .supported (supported)
   );

   always_ff @(posedge clk) begin
      if (start) begin
         cmd_r     <= req.cmd;
         dstaddr_r <= req.dstaddr;
         srcaddr_r <= req.srcaddr;
         wdata_r   <= req.data[APB_RW-1:0];
      end
   end

   // ########################################################################
   // APB sequencing
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         enable_r <= 1'b0;
      end else if (start) begin
         enable_r <= 1'b1;                              // Access phase next cycle
      end else if (done) begin
         enable_r <= 1'b0;
      end
   end

   always_comb begin
      apb_req.sel    = start | enable_r;                // Setup driven in accept cycle
      apb_req.enable = enable_r;
      apb_req.write  = is_write | is_posted;
      apb_req.addr   = APB_AW'(cur_dstaddr[UMI_GRP_OFFSET-1:0]);  // Offset below group
      apb_req.wdata  = accept ? req.data[APB_RW-1:0] : wdata_r;
      apb_req.strb   = '1;                              // Full word writes only
      apb_req.prot   = {1'b0, cur_cmd.prot};
   end

   // ########################################################################
   // Response side
   // ########################################################################
   always_comb begin
      resp_cmd        = cmd_r;                          // Keeps len, atype, prot, hostid
      resp_cmd.opcode = is_read ? UMI_RESP_READ : UMI_RESP_WRITE;
      resp_cmd.err    = apb_resp.slverr ? UMI_ERR_SLV : 2'b00;
   end

   always_ff @(posedge clk) begin
      if (done) begin
         resp_r.cmd     <= resp_cmd;
         resp_r.dstaddr <= srcaddr_r;                   // Back to the requester
         resp_r.srcaddr <= dstaddr_r;
         resp_r.data    <= {{(UMI_DW - APB_RW){1'b0}}, apb_resp.rdata};
      end
   end

   // Posted writes finish on done without a response
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         resp_valid_r <= 1'b0;
      end else if (done & ~is_posted) begin
         resp_valid_r <= 1'b1;
      end else if (resp_valid_r & resp_ready) begin
         resp_valid_r <= 1'b0;
      end
   end

   assign resp_valid = resp_valid_r;
   assign resp       = resp_r;

endmodule

// File: src/apb_regfile.sv
// APB register file target, sixteen words with one read wait state and unmapped error
`timescale 1ns/1ps

module apb_regfile import apb_pkg::*; (
   input  logic      clk,
   input  logic      nreset,
   input  apb_req_t  apb_req,
   output apb_resp_t apb_resp
);

   logic [APB_RW-1:0]    regs [APB_NREGS];
   logic [APB_IDX_W-1:0] idx;                           // Word index
   logic                 mapped;                        // Address inside the file
   logic                 access;                        // Access phase
   logic                 wait_r;                        // Read wait state done

   assign idx    = apb_req.addr[APB_IDX_W+1:2];
   assign mapped = (apb_req.addr < APB_MAP_BYTES);
   assign access = apb_req.sel & apb_req.enable;

   // ########################################################################
   // Read wait state
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wait_r <= 1'b0;
      end else begin
         wait_r <= access & ~apb_req.write & mapped & ~wait_r;  // One cycle pulse
      end
   end

   // Writes and errors answer at once, reads after the wait
   always_comb begin
      apb_resp.ready  = access & (apb_req.write | ~mapped | wait_r);
      apb_resp.slverr = access & ~mapped;
      apb_resp.rdata  = '0;                             // Zero on writes and errors
      if (access & ~apb_req.write & mapped) begin
         apb_resp.rdata = regs[idx];
      end
   end

   // ########################################################################
   // Register storage
   // ########################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < APB_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (access & apb_req.write & mapped) begin
         for (int b = 0; b < APB_RW / 8; b++) begin
            if (apb_req.strb[b]) begin
               regs[idx][b*8 +: 8] <= apb_req.wdata[b*8 +: 8];  // Byte lane
            end
         end
      end
   end

endmodule

// File: src/umi_apb_top.sv
// UMI to APB subsystem, bridge driving the register file target
`timescale 1ns/1ps

module umi_apb_top import umi_pkg::*, apb_pkg::*; (
   input  logic     clk,
   input  logic     nreset,
   // UMI request
   input  logic     req_valid,
   input  umi_pkt_t req,
   output logic     req_ready,
   // UMI response
   output logic     resp_valid,
   output umi_pkt_t resp,
   input  logic     resp_ready
);

   apb_req_t  apb_req;                                  // Bridge to target
   apb_resp_t apb_resp;                                 // Target to bridge

   umi_apb_bridge bridge_i (
      .clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready),
      .apb_req    (apb_req),
      .apb_resp   (apb_resp)
   );

   apb_regfile regfile_i (
      .clk      (clk),
      .nreset   (nreset),
      .apb_req  (apb_req),
      .apb_resp (apb_resp)
   );

endmodule

// File: bench/umi_apb_sva.sv
// Bound checks on bridge APB phase sequencing and UMI response hold
`timescale 1ns/1ps

module umi_apb_sva import umi_pkg::*, apb_pkg::*; (
   input logic      clk,
   input logic      nreset,
   input apb_req_t  apb_req,
   input apb_resp_t apb_resp,
   input logic      resp_valid,
   input umi_pkt_t  resp,
   input logic      resp_ready
);

   int fail_cnt = 0;                                    // Failed assertion count

   // ########################################################################
   // APB phases
   // ########################################################################
   enable_after_setup: assert property (@(posedge clk) disable iff (!nreset)
      $rose(apb_req.enable) |-> $past(apb_req.sel & ~apb_req.enable))
   else begin
      $error("APB access phase without a setup cycle before it");
      fail_cnt++;
   end

   // Sel holds through wait states
   sel_until_ready: assert property (@(posedge clk) disable iff (!nreset)
      apb_req.sel & ~apb_resp.ready |=> apb_req.sel)
   else begin
      $error("APB sel dropped before ready");
      fail_cnt++;
   end

   // ########################################################################
   // UMI response hold
   // ########################################################################
   resp_stable: assert property (@(posedge clk) disable iff (!nreset)
      resp_valid & ~resp_ready |=> resp_valid && $stable(resp))
   else begin
      $error("UMI response changed or dropped while stalled");
      fail_cnt++;
   end

endmodule

// File: bench/umi_apb_tb.sv
// Testbench for the UMI to APB subsystem, table driven with random response back-pressure
`timescale 1ns/1ps

module umi_apb_tb import umi_pkg::*; ();

   localparam int          NUM_STIM     = 14;
   localparam int          QUIET_CYCLES = 4;            // Longest latency is 3
   localparam logic [63:0] SRC_BASE     = 64'h0000_00C0_0000_0000;

   // One table row, request then expected response
   typedef struct packed {
      logic [4:0]  opcode;
      logic [2:0]  size;
      logic [31:0] dstaddr;                             // Upper word zero
      logic [31:0] wdata;
      logic        has_resp;
      logic [4:0]  resp_op;
      logic [1:0]  resp_err;
      logic [31:0] rdata;
   } stim_t;

   logic        clk;
   logic        nreset;
   logic        req_valid;
   umi_pkt_t    req;
   logic        req_ready;
   logic        resp_valid;
   umi_pkt_t    resp;
   logic        resp_ready;

   stim_t       stim [NUM_STIM];
   logic [31:0] lcg_state;
   int          cur_entry;                              // For error lines
   int          val_errs;
   int          proto_errs;

   umi_apb_top umi_apb_top_i (
      .clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready)
   );

   bind umi_apb_bridge umi_apb_sva sva_i (
      .clk        (clk),
      .nreset     (nreset),
      .apb_req    (apb_req),
      .apb_resp   (apb_resp),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready)
   );

   always #20 clk = ~clk;                               // 40 ns period

   // ########################################################################
   // Stimulus helpers
   // ########################################################################
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // One clock, inputs change on the falling edge
   task automatic next_cycle();
      @(negedge clk);
      lcg_state  = lcg_next(lcg_state);
      resp_ready = (lcg_state[17:16] != 2'b00);         // Ready about 3 of 4 cycles
   endtask

   task automatic check_cmd(input umi_cmd_t got, input umi_cmd_t exp);
      if (got.opcode !== exp.opcode) begin
         $display("ERR resp.cmd.opcode got 0x%h expected 0x%h (entry %0d)",
                  got.opcode, exp.opcode, cur_entry);
         val_errs++;
      end
      if (got.err !== exp.err) begin
         $display("ERR resp.cmd.err got 0x%h expected 0x%h (entry %0d)",
                  got.err, exp.err, cur_entry);
         val_errs++;
      end
      // Fields echoed from the request
      if ({got.len, got.prot, got.hostid} !== {exp.len, exp.prot, exp.hostid}) begin
         $display("ERR resp.cmd len,prot,hostid got 0x%h expected 0x%h (entry %0d)",
                  {got.len, got.prot, got.hostid}, {exp.len, exp.prot, exp.hostid}, cur_entry);
         val_errs++;
      end
   endtask

   task automatic check_data(input logic [UMI_DW-1:0] got, input logic [UMI_DW-1:0] exp);
      if (got !== exp) begin
         $display("ERR resp.data got 0x%h expected 0x%h (entry %0d)", got, exp, cur_entry);
         val_errs++;
      end
   endtask

   task automatic check_addr(input logic [UMI_AW-1:0] got_dst, got_src, exp_dst, exp_src);
      if (got_dst !== exp_dst) begin
         $display("ERR resp.dstaddr got 0x%h expected 0x%h (entry %0d)",
                  got_dst, exp_dst, cur_entry);
         val_errs++;
      end
      if (got_src !== exp_src) begin
         $display("ERR resp.srcaddr got 0x%h expected 0x%h (entry %0d)",
                  got_src, exp_src, cur_entry);
         val_errs++;
      end
   endtask

   task automatic apply_entry(input int idx);
      stim_t    s;
      umi_pkt_t pkt;
      umi_cmd_t exp_cmd;
      logic     stray;
      s              = stim[idx];
      cur_entry      = idx;
      pkt            = '0;
      pkt.cmd.opcode = s.opcode;
      pkt.cmd.size   = s.size;
      pkt.cmd.len    = 8'(8'h30 + idx);                 // Ignored by the target
      pkt.cmd.prot   = 2'(idx / 2);
      pkt.cmd.hostid = 2'(idx);
      pkt.dstaddr    = {32'h0, s.dstaddr};
      pkt.srcaddr    = SRC_BASE | 64'(idx);
      pkt.data       = {~s.wdata, s.wdata};             // Upper word is not carried
      while (!req_ready) begin
         next_cycle();
      end
      req_valid = 1'b1;
      req       = pkt;
      next_cycle();                                     // Taken on the rising edge
      req_valid = 1'b0;
      if (s.has_resp) begin
         while (!(resp_valid && resp_ready)) begin
            next_cycle();
         end
         exp_cmd        = pkt.cmd;
         exp_cmd.opcode = s.resp_op;
         exp_cmd.err    = s.resp_err;
         check_cmd(resp.cmd, exp_cmd);
         check_data(resp.data, {32'h0, s.rdata});      // Zero-extended read word
         check_addr(resp.dstaddr, resp.srcaddr, pkt.srcaddr, pkt.dstaddr);
      end else begin
         stray = 1'b0;
         repeat (QUIET_CYCLES) begin
            stray = stray | resp_valid;
            next_cycle();
         end
         if (stray) begin
            $display("Entry %0d returned a response although none was expected", idx);
            proto_errs++;
         end
      end
   endtask

   // ########################################################################
   // Main sequence
   // ########################################################################
   initial begin
      int sva_errs;
      clk        = 1'b0;
      nreset     = 1'b0;
      req_valid  = 1'b0;
      req        = '0;
      resp_ready = 1'b0;
      lcg_state  = 32'h1a39;
      cur_entry  = 0;
      val_errs   = 0;
      proto_errs = 0;
      // Group 5A with the register offset in the low address bits
      // Request opcode size dstaddr wdata then response flag and expected opcode err rdata
      stim = '{
         '{UMI_REQ_WRITE,  3'd2, 32'h5A000008, 32'h12345678, 1'b1, UMI_RESP_WRITE, 2'h0, 32'h0},
         '{UMI_REQ_READ,   3'd2, 32'h5A000008, 32'h00000000, 1'b1, UMI_RESP_READ,  2'h0, 32'h12345678},
         '{UMI_REQ_POSTED, 3'd2, 32'h5A00000C, 32'hCAFEF00D, 1'b0, 5'd0,           2'h0, 32'h0},
         '{UMI_REQ_READ,   3'd2, 32'h5A00000C, 32'h00000000, 1'b1, UMI_RESP_READ,  2'h0, 32'hCAFEF00D},
         '{UMI_REQ_WRITE,  3'd2, 32'h5A000040, 32'hA5A5A5A5, 1'b1, UMI_RESP_WRITE, 2'h2, 32'h0},
         '{UMI_REQ_READ,   3'd2, 32'h5A000100, 32'h00000000, 1'b1, UMI_RESP_READ,  2'h2, 32'h0},
         // Group, size, alignment, RDMA and atomic drops
         '{UMI_REQ_WRITE,  3'd2, 32'h5B000010, 32'h11111111, 1'b0, 5'd0,           2'h0, 32'h0},
         '{UMI_REQ_WRITE,  3'd3, 32'h5A000010, 32'h22222222, 1'b0, 5'd0,           2'h0, 32'h0},
         '{UMI_REQ_WRITE,  3'd2, 32'h5A000012, 32'h33333333, 1'b0, 5'd0,           2'h0, 32'h0},
         '{UMI_REQ_RDMA,   3'd2, 32'h5A000010, 32'h44444444, 1'b0, 5'd0,           2'h0, 32'h0},
         '{UMI_REQ_ATOMIC, 3'd2, 32'h5A000010, 32'h55555555, 1'b0, 5'd0,           2'h0, 32'h0},
         '{UMI_REQ_READ,   3'd2, 32'h5A000010, 32'h00000000, 1'b1, UMI_RESP_READ,  2'h0, 32'h0},
         '{UMI_REQ_POSTED, 3'd2, 32'h5A00003C, 32'h66666666, 1'b0, 5'd0,           2'h0, 32'h0},
         '{UMI_REQ_READ,   3'd2, 32'h5A00003C, 32'h00000000, 1'b1, UMI_RESP_READ,  2'h0, 32'h66666666}
      };
      repeat (5) begin
         next_cycle();
      end
      if (!req_ready || resp_valid) begin
         $display("Reset state wrong, req_ready should be high and resp_valid low");
         proto_errs++;
      end
      nreset = 1'b1;
      for (int i = 0; i < NUM_STIM; i++) begin
         apply_entry(i);
      end
      sva_errs = umi_apb_top_i.bridge_i.sva_i.fail_cnt;
      $display("Error count %0d value, %0d protocol, %0d assertion",
               val_errs, proto_errs, sva_errs);
      if (val_errs + proto_errs + sva_errs == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // Twenty cycles per table row
   initial begin
      #(NUM_STIM * 20 * 40);
      $display("Watchdog expired before the stimulus table finished");
      $display("Result: FAILED");
      $finish;
   end

endmodule

// File: flist.f
src/umi_pkg.sv
src/apb_pkg.sv
src/umi_cmd_decode.sv
src/umi_apb_bridge.sv
src/apb_regfile.sv
src/umi_apb_top.sv
bench/umi_apb_sva.sv
bench/umi_apb_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the UMI to APB testbench
verilator --binary --assert --timescale 1ns/1ps -j 0 \
   --top-module umi_apb_tb -f flist.f -o umi_apb_sim \
   && ./obj_dir/umi_apb_sim | tee /dev/stderr | grep "Result: PASSED" > /dev/null \
   && echo "Simulation run passed" \
   || { echo "Simulation run failed"; exit 1; }
